// ==== all.f ====
+incdir+.
median_pkg.sv
window_if.sv
sort3.sv
column_sorter.sv
row_sorter.sv
diagonal_median.sv
median_filter_3x3.sv
median_filter_asserts.sv
tb_median_filter.sv

// ==== column_sorter.sv ====
`include "median_config.svh"

module column_sorter (
    input  logic  i_clk,
    input  logic  i_rst,
    window_if.dst win_i,
    window_if.src win_o
);

    // Columns gathered into rows for the sorters
    median_pkg::row_t    col_in  [`MF_WIN];
    median_pkg::row_t    col_srt [`MF_WIN];
    median_pkg::window_t win_nxt;
    median_pkg::window_t win_q;
    logic                valid_q;

    //////////////////////////////////////////////////
    // Column sort
    //////////////////////////////////////////////////

    // Transpose so each sorter sees one column
    always_comb begin
        for (int c = 0; c < `MF_WIN; c++) begin
            for (int r = 0; r < `MF_WIN; r++) begin
                col_in[c][r] = win_i.win[r][c];
            end
        end
    end

    for (genvar c = 0; c < `MF_WIN; c++) begin : g_col
        sort3 u_sort (
            .i_vals   (col_in[c]),
            .o_sorted (col_srt[c])
        );
    end

    // Back into place, smallest of each column in row 0
    always_comb begin
        for (int c = 0; c < `MF_WIN; c++) begin
            for (int r = 0; r < `MF_WIN; r++) begin
                win_nxt[r][c] = col_srt[c][r];
            end
        end
    end

    //////////////////////////////////////////////////
    // Pipeline register
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= 1'b0;
            win_q   <= '0;
        end else begin
            valid_q <= win_i.valid;
            if (win_i.valid) begin
                win_q <= win_nxt;
            end
        end
    end

    assign win_o.valid = valid_q;
    assign win_o.win   = win_q;

endmodule

// ==== diagonal_median.sv ====
`include "median_config.svh"

module diagonal_median (
    input  logic               i_clk,
    input  logic               i_rst,
    window_if.dst              win_i,
    output median_pkg::pixel_t o_median,
    output logic               o_valid
);

    median_pkg::row_t   diag;
    median_pkg::row_t   diag_srt;
    median_pkg::pixel_t median_q;
    logic               valid_q;

    //////////////////////////////////////////////////
    // Anti-diagonal sort
    //////////////////////////////////////////////////

    // Top right to bottom left
    // (0,2) (1,1) (2,0)
    always_comb begin
        for (int r = 0; r < `MF_WIN; r++) begin
            diag[r] = win_i.win[r][`MF_WIN-1-r];
        end
    end

    sort3 u_sort (
        .i_vals   (diag),
        .o_sorted (diag_srt)
    );

    //////////////////////////////////////////////////
    // Median register
    //////////////////////////////////////////////////

    // Middle of the sorted diagonal is the median of all nine
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q  <= 1'b0;
            median_q <= '0;
        end else begin
            valid_q <= win_i.valid;
            if (win_i.valid) begin
                median_q <= diag_srt[`MF_WIN/2];
            end
        end
    end

    // Held while no new window arrives
    assign o_median = median_q;
    assign o_valid  = valid_q;

endmodule

// ==== median_config.svh ====
`ifndef MEDIAN_CONFIG_SVH
`define MEDIAN_CONFIG_SVH

//////////////////////////////////////////////////
// Median filter configuration
//////////////////////////////////////////////////

// Bits per pixel
`define MF_PIXEL_W 8

// Side length of the square window
`define MF_WIN 3

// Register stages between window in and median out
`define MF_LATENCY 3

`endif

// ==== median_filter_3x3.sv ====
module median_filter_3x3 (
    input  logic               i_clk,
    input  logic               i_rst,

    // One full window per valid cycle
    input  logic               i_valid,

    // Row 0
    input  median_pkg::pixel_t i_pixel_00,
    input  median_pkg::pixel_t i_pixel_01,
    input  median_pkg::pixel_t i_pixel_02,

    // Row 1
    input  median_pkg::pixel_t i_pixel_10,
    input  median_pkg::pixel_t i_pixel_11,
    input  median_pkg::pixel_t i_pixel_12,

    // Row 2
    input  median_pkg::pixel_t i_pixel_20,
    input  median_pkg::pixel_t i_pixel_21,
    input  median_pkg::pixel_t i_pixel_22,

    output median_pkg::pixel_t o_median,
    output logic               o_valid
);

    //////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////

    // Raw window from the ports
    window_if win_in ();

    // After column sort
    window_if win_col ();

    // After row sort
    window_if win_row ();

    // Highest index sits at the left of each concatenation
    assign win_in.valid = i_valid;
    assign win_in.win   = {
        {i_pixel_22, i_pixel_21, i_pixel_20},
        {i_pixel_12, i_pixel_11, i_pixel_10},
        {i_pixel_02, i_pixel_01, i_pixel_00}
    };

    //////////////////////////////////////////////////
    // Three stage pipeline
    //////////////////////////////////////////////////

    // Stage 1
    column_sorter u_column_sorter (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .win_i (win_in.dst),
        .win_o (win_col.src)
    );

    // Stage 2
    row_sorter u_row_sorter (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .win_i (win_col.dst),
        .win_o (win_row.src)
    );

    // Stage 3, median out
    diagonal_median u_diagonal_median (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .win_i    (win_row.dst),
        .o_median (o_median),
        .o_valid  (o_valid)
    );

endmodule

// ==== median_filter_asserts.sv ====
`include "median_config.svh"

module median_filter_asserts (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  median_pkg::pixel_t o_median,
    input  logic               o_valid
);

    //////////////////////////////////////////////////
    // Reset and valid behavior
    //////////////////////////////////////////////////

    // No output pulse while reset is held
    a_no_valid_in_reset : assert property (
        @(posedge i_clk) i_rst |-> !o_valid
    ) else $error("o_valid high during reset");

    // Output valid is the input valid, delayed by the pipeline depth
    a_valid_latency : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_valid == $past(i_valid, `MF_LATENCY)
    ) else $error("o_valid does not follow i_valid by the pipeline depth");

    // Median holds between pulses
    a_median_hold : assert property (
        @(posedge i_clk) disable iff (i_rst)
        !o_valid |-> $stable(o_median)
    ) else $error("o_median changed while o_valid was low");

endmodule

bind median_filter_3x3 median_filter_asserts u_asserts (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid),
    .o_median (o_median),
    .o_valid  (o_valid)
);

// ==== median_pkg.sv ====
`include "median_config.svh"

package median_pkg;

    //////////////////////////////////////////////////
    // Pixel and window types
    //////////////////////////////////////////////////

    // One unsigned pixel
    typedef logic [`MF_PIXEL_W-1:0] pixel_t;

    // Three pixels, also the unit a sorter works on
    // Index 0 holds the smallest value once sorted
    typedef pixel_t [`MF_WIN-1:0] row_t;

    // Full window, indexed [row][column]
    typedef row_t [`MF_WIN-1:0] window_t;

endpackage

// ==== median_stim.txt ====
// p00 p01 p02 p10 p11 p12 p20 p21 p22 median
// Nine window pixels row by row, then the expected median, all hex
00 00 00 00 00 00 00 00 00 00
ff ff ff ff ff ff ff ff ff ff
80 80 80 80 80 80 80 80 80 80
01 02 03 04 05 06 07 08 09 05
09 08 07 06 05 04 03 02 01 05
00 ff 00 ff 00 ff 00 ff 00 00
ff 00 ff 00 ff 00 ff 00 ff ff
00 00 00 00 ff ff ff ff ff ff
10 10 20 20 30 30 40 40 50 30
55 55 55 55 11 99 99 99 99 55
00 ff 80 7f 81 01 fe 02 fd 80
3c 3c 3c 3c 3c 3c 3c 3c 00 3c
00 00 00 00 00 00 00 00 ff 00
12 34 56 78 9a bc de f0 00 78
a0 05 c3 5e 17 e9 42 8b 30 5e
64 c8 32 96 fa 0a 4b 19 af 64
01 01 02 02 03 03 04 04 05 03
7f 80 7f 80 7f 80 7f 80 7f 7f
80 7f 80 7f 80 7f 80 7f 80 80
ff fe fd fc fb fa f9 f8 f7 fb
00 01 02 03 04 05 06 07 08 04
20 40 60 80 a0 c0 e0 ff 00 80
9c 2d 9c 2d 9c 2d 11 ee 50 50
44 44 44 22 22 22 66 66 66 44
66 22 44 66 22 44 66 22 44 44
05 ff 05 ff 05 ff 05 ff ff ff
c8 00 64 00 c8 64 00 64 c8 64
1e 2d 3c 4b 5a 69 78 87 96 5a
96 87 78 69 5a 4b 3c 2d 1e 5a
5a 1e 96 3c 78 2d 87 4b 69 5a
00 00 01 00 00 01 00 01 01 00
01 01 00 01 01 00 01 00 00 01
ab cd ef 12 34 56 78 9a bc 9a
d7 3b 8e f2 61 09 c4 a5 7d 8e
27 b6 4f e1 93 6a 0c d8 55 6a
fe 01 fe 01 80 01 fe 01 fe 80
10 20 30 10 20 30 10 20 30 20
33 33 33 33 33 33 33 33 34 33
34 33 34 33 34 33 34 33 34 34
e0 d0 c0 b0 a0 90 80 70 60 a0
0f f0 0f f0 0f f0 0f f0 0f 0f
00 ff 00 ff 80 ff 00 ff 00 80
8d 2a f5 63 b9 47 1c d0 7e 7e
5b 5b 9f 9f 03 03 c7 c7 5b 5b

// ==== row_sorter.sv ====
`include "median_config.svh"

module row_sorter (
    input  logic  i_clk,
    input  logic  i_rst,
    window_if.dst win_i,
    window_if.src win_o
);

    // Sorted rows, one per sorter
    median_pkg::row_t    row_srt [`MF_WIN];
    median_pkg::window_t win_nxt;
    median_pkg::window_t win_q;
    logic                valid_q;

    //////////////////////////////////////////////////
    // Row sort
    //////////////////////////////////////////////////

    // Input columns are already sorted, so after this
    // step the window is ordered along both axes
    for (genvar r = 0; r < `MF_WIN; r++) begin : g_row
        sort3 u_sort (
            .i_vals   (win_i.win[r]),
            .o_sorted (row_srt[r])
        );
    end

    // Reassemble the window
    always_comb begin
        for (int r = 0; r < `MF_WIN; r++) begin
            win_nxt[r] = row_srt[r];
        end
    end

    //////////////////////////////////////////////////
    // Pipeline register
    //////////////////////////////////////////////////

    // Valid follows every cycle, data only on valid
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= 1'b0;
            win_q   <= '0;
        end else begin
            valid_q <= win_i.valid;
            if (win_i.valid) begin
                win_q <= win_nxt;
            end
        end
    end

    assign win_o.valid = valid_q;
    assign win_o.win   = win_q;

endmodule

// ==== sort3.sv ====
module sort3 (
    input  median_pkg::row_t i_vals,
    output median_pkg::row_t o_sorted
);

    // Partial results after each compare-exchange
    median_pkg::row_t s1;
    median_pkg::row_t s2;

    // Order slots 0 and 1
    always_comb begin
        s1 = i_vals;
        if (i_vals[0] > i_vals[1]) begin
            s1[0] = i_vals[1];
            s1[1] = i_vals[0];
        end
    end

    // Largest value ends up in slot 2
    always_comb begin
        s2 = s1;
        if (s1[1] > s1[2]) begin
            s2[1] = s1[2];
            s2[2] = s1[1];
        end
    end

    // Last exchange settles min and mid
    always_comb begin
        o_sorted = s2;
        if (s2[0] > s2[1]) begin
            o_sorted[0] = s2[1];
            o_sorted[1] = s2[0];
        end
    end

endmodule

// ==== tb_median_filter.sv ====
`include "median_config.svh"

module tb_median_filter;

    logic               i_clk;
    logic               i_rst;
    logic               i_valid;
    median_pkg::pixel_t i_pixel_00;
    median_pkg::pixel_t i_pixel_01;
    median_pkg::pixel_t i_pixel_02;
    median_pkg::pixel_t i_pixel_10;
    median_pkg::pixel_t i_pixel_11;
    median_pkg::pixel_t i_pixel_12;
    median_pkg::pixel_t i_pixel_20;
    median_pkg::pixel_t i_pixel_21;
    median_pkg::pixel_t i_pixel_22;
    median_pkg::pixel_t o_median;
    logic               o_valid;

    // Flat list, ten fields per vector
    median_pkg::pixel_t pix_mem [$];
    median_pkg::pixel_t exp_q [$];
    int                 stamp_q [$];
    median_pkg::pixel_t last_median = '0;
    median_pkg::pixel_t exp_med;
    int                 stamp;
    int                 cycle_cnt = 0;
    int                 n_vec = 0;
    int                 checked = 0;
    int                 mismatches = 0;
    int                 other_errs = 0;

    median_filter_3x3 dut (.*);

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Stamp is the cycle in which the window sits on the inputs
    task automatic apply_window(input int idx);
        i_valid    = 1'b1;
        i_pixel_00 = pix_mem[idx*10+0];
        i_pixel_01 = pix_mem[idx*10+1];
        i_pixel_02 = pix_mem[idx*10+2];
        i_pixel_10 = pix_mem[idx*10+3];
        i_pixel_11 = pix_mem[idx*10+4];
        i_pixel_12 = pix_mem[idx*10+5];
        i_pixel_20 = pix_mem[idx*10+6];
        i_pixel_21 = pix_mem[idx*10+7];
        i_pixel_22 = pix_mem[idx*10+8];
        exp_q.push_back(pix_mem[idx*10+9]);
        stamp_q.push_back(cycle_cnt);
    endtask

    // Junk pixels while idle must not reach the output
    task automatic apply_idle();
        i_valid    = 1'b0;
        i_pixel_00 = $urandom;
        i_pixel_01 = $urandom;
        i_pixel_02 = $urandom;
        i_pixel_10 = $urandom;
        i_pixel_11 = $urandom;
        i_pixel_12 = $urandom;
        i_pixel_20 = $urandom;
        i_pixel_21 = $urandom;
        i_pixel_22 = $urandom;
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    always @(negedge i_clk) begin
        if (!i_rst) begin
            if (o_valid) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Error at time %0t: o_valid pulse with no window pending", $time);
                end else begin
                    exp_med = exp_q.pop_front();
                    stamp   = stamp_q.pop_front();
                    check_value("median", o_median, exp_med);
                    check_value("latency", cycle_cnt - stamp, `MF_LATENCY);
                    last_median = exp_med;
                    checked++;
                end
            end else begin
                // Also covers the zero median right after reset
                check_value("held median", o_median, last_median);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int                 fd;
        int                 rc;
        int                 gap;
        median_pkg::pixel_t f [10];
        string              line;

        void'($urandom(32'h6a4c_783d));
        i_rst = 1'b1;
        apply_idle();

        fd = $fopen("median_stim.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Error: cannot open median_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                             f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                if (rc == 10) begin
                    for (int k = 0; k < 10; k++) begin
                        pix_mem.push_back(f[k]);
                    end
                end
            end
            $fclose(fd);
        end
        n_vec = pix_mem.size() / 10;
        if (n_vec == 0) begin
            other_errs++;
            $display("Error: no test vectors were read");
        end

        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        repeat (2) @(negedge i_clk);

        for (int i = 0; i < n_vec; i++) begin
            @(negedge i_clk);
            apply_window(i);
            // Vectors 8 to 15 go back to back
            gap = (i >= 8 && i < 16) ? 0 : $urandom % 4;
            for (int g = 0; g < gap; g++) begin
                @(negedge i_clk);
                apply_idle();
            end
        end
        @(negedge i_clk);
        apply_idle();

        // Drain the pipeline, then watch a few idle cycles
        for (int d = 0; d < `MF_LATENCY + 4 && exp_q.size() != 0; d++) begin
            @(negedge i_clk);
        end
        repeat (4) @(negedge i_clk);
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("Error: %0d windows never produced a median", exp_q.size());
        end

        $display("Checked %0d of %0d windows, %0d mismatches, %0d other errors",
                 checked, n_vec, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (n_vec > 0);
        #((n_vec * 5 + 16 + 20) * 8);
        $display("Error: simulation timed out before all windows were checked");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== window_if.sv ====
interface window_if;

    //////////////////////////////////////////////////
    // Stage to stage window transfer
    //////////////////////////////////////////////////

    // High for one cycle per window, no back-pressure
    logic                valid;

    // Pixel payload, indexed [row][column]
    median_pkg::window_t win;

    // Producer side
    modport src (
        output valid,
        output win
    );

    // Consumer side
    modport dst (
        input  valid,
        input  win
    );

endinterface
